// File: common/lpif_link_pkg.sv
package lpif_link_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int LINK_WORD_W = 89;
  localparam int PHY_W       = 80;

  // Upstream and downstream field widths
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int CRC_W    = 16;
  localparam int DATA_W   = 64;

  ////////////////////////////////////////
  // Link word layout

  localparam int VALID_BIT     = 0;
  localparam int CRC_VALID_BIT = 1;
  localparam int DVALID_BIT    = 2;
  localparam int PROTID_LSB    = 3;
  localparam int STATE_LSB     = 5;
  localparam int CRC_LSB       = 9;
  localparam int DATA_LSB      = 25;

  ////////////////////////////////////////
  // Lane layout

  // Lane 0 control bits
  localparam int STB_BIT       = 0;
  localparam int MRK_BIT       = 1;
  localparam int CRD_BIT       = 2;
  // First word bit on lane 0, above the control bits
  localparam int LANE_DATA_LSB = 3;

  // Word bits per beat
  localparam int G2_LANE0_BITS = 77;
  localparam int G2_LANE1_BITS = 12;
  localparam int G1_LANE0_BITS = 37;
  localparam int G1_LANE1_BITS = 40;

  // Link state field
  typedef enum logic [3:0] {
    lpif_reset      = 4'h0,
    lpif_active     = 4'h1,
    lpif_idle       = 4'h2,
    lpif_retrain    = 4'h3,
    lpif_link_error = 4'h4
  } lpif_state_e;

  // Online delay machine
  typedef enum logic [1:0] {
    sync_offline  = 2'd0,
    sync_counting = 2'd1,
    sync_online   = 2'd2
  } sync_state_e;

  // Gen1 beat position
  typedef enum logic {
    phase_first  = 1'b0,
    phase_second = 1'b1
  } beat_phase_e;

endpackage

// File: auto_sync/lpif_auto_sync.sv
`timescale 1ns/1ps

module lpif_auto_sync (
  input  logic       clk_wr,
  input  logic       rst_n,

  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,

  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic [1:0] tx_mrk,
  output logic       tx_stb
);

  // Index 0 is transmit, index 1 is receive
  logic [1:0]      side_en;
  logic [1:0][7:0] side_dly;
  logic [1:0]      side_online;
  // Marker toggle, high means the next beat is a first beat
  logic            mrk_q;

  assign side_en  = {rx_online, tx_online};
  assign side_dly = {delay_x_value, delay_xz_value};

  ////////////////////////////////////////
  // Online delay machines

  for (genvar i = 0; i < 2; i++) begin : g_side
    lpif_link_pkg::sync_state_e state;
    logic [7:0]                 cnt;

    always_ff @(posedge clk_wr) begin
      if (!rst_n) begin
        state <= lpif_link_pkg::sync_offline;
        cnt   <= '0;
      end else if (!side_en[i]) begin
        // Enable dropped, go offline next cycle
        state <= lpif_link_pkg::sync_offline;
        cnt   <= '0;
      end else begin
        case (state)
          lpif_link_pkg::sync_offline: begin
            // Zero delay goes straight online
            if (side_dly[i] == 8'd0) begin
              state <= lpif_link_pkg::sync_online;
            end else begin
              state <= lpif_link_pkg::sync_counting;
              cnt   <= side_dly[i] - 8'd1;
            end
          end
          lpif_link_pkg::sync_counting: begin
            if (cnt == 8'd0) begin
              state <= lpif_link_pkg::sync_online;
            end else begin
              cnt <= cnt - 8'd1;
            end
          end
          // Online holds until the enable falls
          default: state <= lpif_link_pkg::sync_online;
        endcase
      end
    end

    assign side_online[i] = (state == lpif_link_pkg::sync_online);
  end

  assign tx_online_delay = side_online[0];
  assign rx_online_delay = side_online[1];

  ////////////////////////////////////////
  // Strobe and marker

  // Strobe on every beat while online
  assign tx_stb = side_online[0];

  // Preset while offline so the first online beat may start a word
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      mrk_q <= 1'b1;
    end else if (!side_online[0]) begin
      mrk_q <= 1'b1;
    end else begin
      mrk_q <= ~mrk_q;
    end
  end

  // Upper marker bit reserved
  assign tx_mrk = {1'b0, mrk_q};

endmodule

// File: verilog/lpif_field_pack.sv
`timescale 1ns/1ps

module lpif_field_pack (
  input  logic                                   clk_wr,
  input  logic                                   rst_n,
  input  logic                                   tx_accept,

  // Upstream fields
  input  logic [lpif_link_pkg::STATE_W-1:0]      ustrm_state,
  input  logic [lpif_link_pkg::PROTID_W-1:0]     ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]       ustrm_data,
  input  logic                                   ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]        ustrm_crc,
  input  logic                                   ustrm_crc_valid,
  input  logic                                   ustrm_valid,

  output logic [lpif_link_pkg::LINK_WORD_W-1:0]  tx_word,
  output logic                                   tx_word_valid,

  input  logic [lpif_link_pkg::LINK_WORD_W-1:0]  rx_word,
  input  logic                                   rx_word_valid,
  input  logic                                   rx_online_delay,

  // Downstream fields
  output logic [lpif_link_pkg::STATE_W-1:0]      dstrm_state,
  output logic [lpif_link_pkg::PROTID_W-1:0]     dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]       dstrm_data,
  output logic                                   dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]        dstrm_crc,
  output logic                                   dstrm_crc_valid,
  output logic                                   dstrm_valid
);

  lpif_link_pkg::lpif_state_e rx_state;
  logic                       rx_take;

  ////////////////////////////////////////
  // Pack

  always_comb begin
    tx_word = '0;
    // Valid only for words the credit logic took
    tx_word[lpif_link_pkg::VALID_BIT]     = ustrm_valid && tx_accept;
    tx_word[lpif_link_pkg::CRC_VALID_BIT] = ustrm_crc_valid;
    tx_word[lpif_link_pkg::DVALID_BIT]    = ustrm_dvalid;
    tx_word[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W] = ustrm_protid;
    tx_word[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W]   = ustrm_state;
    tx_word[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W]       = ustrm_crc;
    tx_word[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W]     = ustrm_data;
  end

  assign tx_word_valid = tx_accept;

  ////////////////////////////////////////
  // Unpack

  assign rx_take = rx_word_valid && rx_online_delay;

  // Flags and link state
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      dstrm_valid     <= 1'b0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
      rx_state        <= lpif_link_pkg::lpif_reset;
    end else if (rx_take) begin
      dstrm_valid     <= rx_word[lpif_link_pkg::VALID_BIT];
      dstrm_dvalid    <= rx_word[lpif_link_pkg::DVALID_BIT];
      dstrm_crc_valid <= rx_word[lpif_link_pkg::CRC_VALID_BIT];
      rx_state        <= lpif_link_pkg::lpif_state_e'(
                           rx_word[lpif_link_pkg::STATE_LSB +: lpif_link_pkg::STATE_W]);
    end else begin
      // One-cycle flags, state holds
      dstrm_valid     <= 1'b0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc_valid <= 1'b0;
    end
  end

  // Payload holds between words
  always_ff @(posedge clk_wr) begin
    if (rx_take) begin
      dstrm_protid <= rx_word[lpif_link_pkg::PROTID_LSB +: lpif_link_pkg::PROTID_W];
      dstrm_crc    <= rx_word[lpif_link_pkg::CRC_LSB +: lpif_link_pkg::CRC_W];
      dstrm_data   <= rx_word[lpif_link_pkg::DATA_LSB +: lpif_link_pkg::DATA_W];
    end
  end

  assign dstrm_state = rx_state;

endmodule

// File: phy_concat/lpif_phy_concat.sv
`timescale 1ns/1ps

module lpif_phy_concat (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic                                  m_gen2_mode,
  input  logic                                  tx_online_delay,
  input  logic                                  rx_online_delay,
  input  logic                                  tx_stb,
  input  logic [1:0]                            tx_mrk,

  input  logic [lpif_link_pkg::LINK_WORD_W-1:0] tx_word,
  input  logic                                  tx_word_valid,
  input  logic                                  crd_return_req,

  // PHY lanes
  output logic [lpif_link_pkg::PHY_W-1:0]       tx_phy0,
  output logic [lpif_link_pkg::PHY_W-1:0]       tx_phy1,
  input  logic [lpif_link_pkg::PHY_W-1:0]       rx_phy0,
  input  logic [lpif_link_pkg::PHY_W-1:0]       rx_phy1,

  output logic [lpif_link_pkg::LINK_WORD_W-1:0] rx_word,
  output logic                                  rx_word_valid,
  output logic                                  crd_return_seen,
  output logic                                  tx_busy
);

  // Gen1 first beat carries the head, second beat the tail
  localparam int G1_HEAD_W = lpif_link_pkg::G1_LANE0_BITS + lpif_link_pkg::G1_LANE1_BITS;
  localparam int G1_TAIL_W = lpif_link_pkg::LINK_WORD_W - G1_HEAD_W;
  localparam int DLSB      = lpif_link_pkg::LANE_DATA_LSB;

  lpif_link_pkg::beat_phase_e              tx_phase;
  lpif_link_pkg::beat_phase_e              tx_phase_nxt;
  logic [lpif_link_pkg::LINK_WORD_W-1:0]   tx_beat_word;
  logic [G1_TAIL_W-1:0]                    tx_hold;
  logic [lpif_link_pkg::PHY_W-1:0]         tx_lane0_nxt;
  logic [lpif_link_pkg::PHY_W-1:0]         tx_lane1_nxt;

  logic                                    rx_stb;
  logic                                    rx_mrk;
  logic                                    rx_head_ok;
  logic [G1_HEAD_W-1:0]                    rx_hold;
  logic [lpif_link_pkg::LINK_WORD_W-1:0]   rx_g2_word;

  ////////////////////////////////////////
  // Transmit

  // Idle beats carry a zero word
  assign tx_beat_word = tx_word_valid ? tx_word : '0;
  assign tx_phase_nxt = (tx_mrk == 2'b01) ? lpif_link_pkg::phase_first
                                          : lpif_link_pkg::phase_second;
  // No word may start while a Gen1 head is on the wire
  assign tx_busy = !m_gen2_mode && (tx_phase == lpif_link_pkg::phase_first);

  always_comb begin
    tx_lane0_nxt = '0;
    tx_lane1_nxt = '0;
    tx_lane0_nxt[lpif_link_pkg::STB_BIT] = tx_stb;
    tx_lane0_nxt[lpif_link_pkg::CRD_BIT] = crd_return_req;
    if (m_gen2_mode) begin
      // Whole word in one beat, every beat marked
      tx_lane0_nxt[lpif_link_pkg::MRK_BIT] = 1'b1;
      tx_lane0_nxt[DLSB +: lpif_link_pkg::G2_LANE0_BITS] =
        tx_beat_word[0 +: lpif_link_pkg::G2_LANE0_BITS];
      tx_lane1_nxt[0 +: lpif_link_pkg::G2_LANE1_BITS] =
        tx_beat_word[lpif_link_pkg::G2_LANE0_BITS +: lpif_link_pkg::G2_LANE1_BITS];
    end else if (tx_phase_nxt == lpif_link_pkg::phase_first) begin
      // Gen1 head, low 40 bits of each lane
      tx_lane0_nxt[lpif_link_pkg::MRK_BIT] = 1'b1;
      tx_lane0_nxt[DLSB +: lpif_link_pkg::G1_LANE0_BITS] =
        tx_beat_word[0 +: lpif_link_pkg::G1_LANE0_BITS];
      tx_lane1_nxt[0 +: lpif_link_pkg::G1_LANE1_BITS] =
        tx_beat_word[lpif_link_pkg::G1_LANE0_BITS +: lpif_link_pkg::G1_LANE1_BITS];
    end else begin
      // Gen1 tail, marker clear
      tx_lane0_nxt[DLSB +: G1_TAIL_W] = tx_hold;
    end
  end

  // Tail kept for the second beat
  always_ff @(posedge clk_wr) begin
    if (tx_phase_nxt == lpif_link_pkg::phase_first) begin
      tx_hold <= tx_beat_word[G1_HEAD_W +: G1_TAIL_W];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0  <= '0;
      tx_phy1  <= '0;
      tx_phase <= lpif_link_pkg::phase_second;
    end else if (!tx_online_delay) begin
      // Quiet lanes while offline
      tx_phy0  <= '0;
      tx_phy1  <= '0;
      tx_phase <= lpif_link_pkg::phase_second;
    end else begin
      tx_phy0  <= tx_lane0_nxt;
      tx_phy1  <= tx_lane1_nxt;
      tx_phase <= tx_phase_nxt;
    end
  end

  ////////////////////////////////////////
  // Receive

  // Only strobed beats count
  assign rx_stb = rx_online_delay && rx_phy0[lpif_link_pkg::STB_BIT];
  assign rx_mrk = rx_phy0[lpif_link_pkg::MRK_BIT];
  assign crd_return_seen = rx_stb && rx_phy0[lpif_link_pkg::CRD_BIT];

  assign rx_g2_word = {rx_phy1[0 +: lpif_link_pkg::G2_LANE1_BITS],
                       rx_phy0[DLSB +: lpif_link_pkg::G2_LANE0_BITS]};

  // Gen1 head capture
  always_ff @(posedge clk_wr) begin
    if (!m_gen2_mode && rx_stb && rx_mrk) begin
      rx_hold <= {rx_phy1[0 +: lpif_link_pkg::G1_LANE1_BITS],
                  rx_phy0[DLSB +: lpif_link_pkg::G1_LANE0_BITS]};
    end
  end

  // Head seen with its valid bit, waiting for the tail
  always_ff @(posedge clk_wr) begin
    if (!rst_n || m_gen2_mode) begin
      rx_head_ok <= 1'b0;
    end else if (rx_stb) begin
      rx_head_ok <= rx_mrk && rx_phy0[DLSB + lpif_link_pkg::VALID_BIT];
    end
  end

  always_comb begin
    if (m_gen2_mode) begin
      rx_word       = rx_g2_word;
      rx_word_valid = rx_stb && rx_g2_word[lpif_link_pkg::VALID_BIT];
    end else begin
      rx_word       = {rx_phy0[DLSB +: G1_TAIL_W], rx_hold};
      rx_word_valid = rx_stb && !rx_mrk && rx_head_ok;
    end
  end

endmodule

// File: verilog/lpif_credit_ctrl.sv
`timescale 1ns/1ps

module lpif_credit_ctrl #(
  parameter int CREDIT_W = 8
) (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                tx_online_delay,
  input  logic [CREDIT_W-1:0] init_upstream_credit,

  input  logic                ustrm_valid,
  input  logic                tx_busy,
  input  logic                crd_return_seen,
  input  logic                rx_word_delivered,

  output logic                ustrm_credit_ok,
  output logic                tx_accept,
  output logic                crd_return_req,

  output logic [31:0]         tx_upstream_debug_status,
  output logic [31:0]         rx_downstream_debug_status
);

  logic [CREDIT_W-1:0] credit_cnt;
  // Credits owed to the far side
  logic [CREDIT_W-1:0] pend_cnt;
  logic                credit_up;
  logic                pend_up;

  assign ustrm_credit_ok = tx_online_delay && (credit_cnt != '0) && !tx_busy;
  assign tx_accept       = ustrm_valid && ustrm_credit_ok;
  // One return per transmitted beat
  assign crd_return_req  = tx_online_delay && (pend_cnt != '0);

  // Saturate at the top
  assign credit_up = crd_return_seen && (credit_cnt != '1);
  assign pend_up   = rx_word_delivered && (pend_cnt != '1);

  ////////////////////////////////////////
  // Credit counters

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else if (!tx_online_delay) begin
      // Ready with the initial grant when going online
      credit_cnt <= init_upstream_credit;
    end else if (credit_up && !tx_accept) begin
      credit_cnt <= credit_cnt + 1'b1;
    end else if (tx_accept && !credit_up) begin
      credit_cnt <= credit_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online_delay) begin
      pend_cnt <= '0;
    end else if (pend_up && !crd_return_req) begin
      pend_cnt <= pend_cnt + 1'b1;
    end else if (crd_return_req && !pend_up) begin
      pend_cnt <= pend_cnt - 1'b1;
    end
  end

  // Debug: dropped offers and delivered words
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_upstream_debug_status   <= '0;
      rx_downstream_debug_status <= '0;
    end else begin
      if (ustrm_valid && !ustrm_credit_ok) begin
        tx_upstream_debug_status <= tx_upstream_debug_status + 32'd1;
      end
      if (rx_word_delivered) begin
        rx_downstream_debug_status <= rx_downstream_debug_status + 32'd1;
      end
    end
  end

endmodule

// File: verilog/lpif_link_top.sv
`timescale 1ns/1ps

module lpif_link_top #(
  parameter int CREDIT_W = 8
) (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,

  // Control
  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  logic [CREDIT_W-1:0]                   init_upstream_credit,

  // PHY lanes
  output logic [lpif_link_pkg::PHY_W-1:0]       tx_phy0,
  input  logic [lpif_link_pkg::PHY_W-1:0]       rx_phy0,
  output logic [lpif_link_pkg::PHY_W-1:0]       tx_phy1,
  input  logic [lpif_link_pkg::PHY_W-1:0]       rx_phy1,

  // Downstream
  output logic [lpif_link_pkg::STATE_W-1:0]     dstrm_state,
  output logic [lpif_link_pkg::PROTID_W-1:0]    dstrm_protid,
  output logic [lpif_link_pkg::DATA_W-1:0]      dstrm_data,
  output logic                                  dstrm_dvalid,
  output logic [lpif_link_pkg::CRC_W-1:0]       dstrm_crc,
  output logic                                  dstrm_crc_valid,
  output logic                                  dstrm_valid,

  // Upstream
  input  logic [lpif_link_pkg::STATE_W-1:0]     ustrm_state,
  input  logic [lpif_link_pkg::PROTID_W-1:0]    ustrm_protid,
  input  logic [lpif_link_pkg::DATA_W-1:0]      ustrm_data,
  input  logic                                  ustrm_dvalid,
  input  logic [lpif_link_pkg::CRC_W-1:0]       ustrm_crc,
  input  logic                                  ustrm_crc_valid,
  input  logic                                  ustrm_valid,
  output logic                                  ustrm_credit_ok,

  // Debug
  output logic [31:0]                           rx_downstream_debug_status,
  output logic [31:0]                           tx_upstream_debug_status,

  // Config
  input  logic                                  m_gen2_mode,
  input  logic [7:0]                            delay_x_value,
  input  logic [7:0]                            delay_xz_value
);

  ////////////////////////////////////////
  // Internal wires

  logic [lpif_link_pkg::LINK_WORD_W-1:0] tx_word;
  logic                                  tx_word_valid;
  logic [lpif_link_pkg::LINK_WORD_W-1:0] rx_word;
  logic                                  rx_word_valid;
  logic                                  tx_accept;
  logic                                  tx_busy;
  logic                                  crd_return_req;
  logic                                  crd_return_seen;
  logic                                  tx_online_delay;
  logic                                  rx_online_delay;
  logic [1:0]                            tx_mrk;
  logic                                  tx_stb;

  ////////////////////////////////////////
  // Blocks

  lpif_auto_sync i_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk          (tx_mrk),
    .tx_stb          (tx_stb)
  );

  lpif_field_pack i_field_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_accept       (tx_accept),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_word         (tx_word),
    .tx_word_valid   (tx_word_valid),
    .rx_word         (rx_word),
    .rx_word_valid   (rx_word_valid),
    .rx_online_delay (rx_online_delay),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  lpif_phy_concat i_phy_concat (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .m_gen2_mode     (m_gen2_mode),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb          (tx_stb),
    .tx_mrk          (tx_mrk),
    .tx_word         (tx_word),
    .tx_word_valid   (tx_word_valid),
    .crd_return_req  (crd_return_req),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_word         (rx_word),
    .rx_word_valid   (rx_word_valid),
    .crd_return_seen (crd_return_seen),
    .tx_busy         (tx_busy)
  );

  // Delivered words drive the credit returns
  lpif_credit_ctrl #(
    .CREDIT_W (CREDIT_W)
  ) i_credit_ctrl (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online_delay            (tx_online_delay),
    .init_upstream_credit       (init_upstream_credit),
    .ustrm_valid                (ustrm_valid),
    .tx_busy                    (tx_busy),
    .crd_return_seen            (crd_return_seen),
    .rx_word_delivered          (dstrm_valid),
    .ustrm_credit_ok            (ustrm_credit_ok),
    .tx_accept                  (tx_accept),
    .crd_return_req             (crd_return_req),
    .tx_upstream_debug_status   (tx_upstream_debug_status),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

endmodule

// File: tb/lpif_link_tb.sv
`timescale 1ns/1ps

module lpif_link_tb;

  localparam int DELAY_X     = 3;
  localparam int DELAY_XZ    = 5;
  localparam int INIT_CREDIT = 4;
  // Test lengths in cycles
  localparam int RESET_CYCLES = 8;
  localparam int G2_CYCLES    = 40;
  localparam int G1_CYCLES    = 40;
  localparam int EXH_CYCLES   = 10;
  localparam int REC_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES =
    4 * (RESET_CYCLES + G2_CYCLES + G1_CYCLES + EXH_CYCLES + REC_CYCLES) + 200;

  logic        clk_wr;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  logic        loop_en;
  logic        m_gen2_mode;
  logic [7:0]  init_upstream_credit;
  logic [7:0]  delay_x_value;
  logic [7:0]  delay_xz_value;
  logic [79:0] tx_phy0;
  logic [79:0] tx_phy1;
  logic [79:0] rx_phy0;
  logic [79:0] rx_phy1;
  logic [3:0]  dstrm_state;
  logic [1:0]  dstrm_protid;
  logic [63:0] dstrm_data;
  logic        dstrm_dvalid;
  logic [15:0] dstrm_crc;
  logic        dstrm_crc_valid;
  logic        dstrm_valid;
  logic [3:0]  ustrm_state;
  logic [1:0]  ustrm_protid;
  logic [63:0] ustrm_data;
  logic        ustrm_dvalid;
  logic [15:0] ustrm_crc;
  logic        ustrm_crc_valid;
  logic        ustrm_valid;
  logic        ustrm_credit_ok;
  logic [31:0] rx_downstream_debug_status;
  logic [31:0] tx_upstream_debug_status;

  integer      seed;
  int          cycle_cnt;
  int          exp_drop;
  int          delivered_cnt;
  int          accept_cnt;
  int          exhaust_accepts;
  bit          exhaust_phase;
  bit          gen1_accept_q;
  // Expected words {state, protid, dvalid, crc_valid, crc, data} and due cycles
  logic [87:0] sb_words[$];
  int          sb_due[$];

  lpif_link_top #(
    .CREDIT_W (8)
  ) i_lpif_link_top (
    .clk_wr (clk_wr), .rst_n (rst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .init_upstream_credit (init_upstream_credit),
    .tx_phy0 (tx_phy0), .rx_phy0 (rx_phy0), .tx_phy1 (tx_phy1), .rx_phy1 (rx_phy1),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .ustrm_credit_ok (ustrm_credit_ok),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status (tx_upstream_debug_status),
    .m_gen2_mode (m_gen2_mode), .delay_x_value (delay_x_value),
    .delay_xz_value (delay_xz_value)
  );

  // PHY loopback with cut lanes reading as zero
  assign rx_phy0 = loop_en ? tx_phy0 : '0;
  assign rx_phy1 = loop_en ? tx_phy1 : '0;

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Failure reporting

  task automatic fail_value(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    $display("ERROR %s: got %0h, expected %0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic fail_text(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Lanes carry nothing without a strobe
  assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_phy0 == '0 && tx_phy1 == '0) || tx_phy0[lpif_link_pkg::STB_BIT])
    else fail_text("tx lanes carry bits while the strobe is clear");

  // Downstream flags only come with a delivered word
  assert property (@(posedge clk_wr) disable iff (!rst_n)
    (dstrm_dvalid || dstrm_crc_valid) |-> dstrm_valid)
    else fail_text("downstream flag set without dstrm_valid");

  ////////////////////////////////////////
  // Monitor and scoreboard

  always @(posedge clk_wr) begin
    logic [87:0] exp_word;
    int          due;
    if (rst_n) begin
      assert (tx_upstream_debug_status == exp_drop)
        else fail_value("tx_upstream_debug_status", tx_upstream_debug_status, exp_drop);
      assert (rx_downstream_debug_status == delivered_cnt)
        else fail_value("rx_downstream_debug_status", rx_downstream_debug_status,
                        delivered_cnt);
      // Gen1 word holds the lanes for two beats
      if (gen1_accept_q) begin
        assert (!ustrm_credit_ok) else fail_value("ustrm_credit_ok", ustrm_credit_ok, 0);
      end
      if (exhaust_phase && exhaust_accepts >= INIT_CREDIT) begin
        assert (!ustrm_credit_ok) else fail_value("ustrm_credit_ok", ustrm_credit_ok, 0);
      end
      if (dstrm_valid) begin
        if (sb_words.size() == 0) begin
          fail_text("dstrm_valid rose with no word expected");
        end else begin
          exp_word = sb_words.pop_front();
          due      = sb_due.pop_front();
          assert (cycle_cnt == due) else fail_value("dstrm_valid cycle", cycle_cnt, due);
          assert (dstrm_data == exp_word[63:0])
            else fail_value("dstrm_data", dstrm_data, exp_word[63:0]);
          assert (dstrm_crc == exp_word[79:64])
            else fail_value("dstrm_crc", dstrm_crc, exp_word[79:64]);
          assert (dstrm_crc_valid == exp_word[80])
            else fail_value("dstrm_crc_valid", dstrm_crc_valid, exp_word[80]);
          assert (dstrm_dvalid == exp_word[81])
            else fail_value("dstrm_dvalid", dstrm_dvalid, exp_word[81]);
          assert (dstrm_protid == exp_word[83:82])
            else fail_value("dstrm_protid", dstrm_protid, exp_word[83:82]);
          assert (dstrm_state == exp_word[87:84])
            else fail_value("dstrm_state", dstrm_state, exp_word[87:84]);
          delivered_cnt++;
        end
      end
      gen1_accept_q = 1'b0;
      if (ustrm_valid && ustrm_credit_ok) begin
        accept_cnt++;
        if (exhaust_phase) exhaust_accepts++;
        gen1_accept_q = !m_gen2_mode;
        // Cut lanes lose the word
        if (loop_en) begin
          sb_words.push_back({ustrm_state, ustrm_protid, ustrm_dvalid, ustrm_crc_valid,
                              ustrm_crc, ustrm_data});
          sb_due.push_back(cycle_cnt + (m_gen2_mode ? 2 : 3));
        end
      end else if (ustrm_valid) begin
        exp_drop++;
      end
    end
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_text("Run did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic drive_word(input bit offer);
    int unsigned idx;
    logic [31:0] rnd;
    idx = {$random(seed)} % 5;
    ustrm_state = lpif_link_pkg::lpif_state_e'(idx[3:0]);
    rnd = $random(seed);
    ustrm_protid    = rnd[1:0];
    ustrm_dvalid    = rnd[2];
    ustrm_crc_valid = rnd[3];
    ustrm_crc       = rnd[31:16];
    ustrm_data      = {$random(seed), $random(seed)};
    ustrm_valid     = offer;
  endtask

  // Offers on about three cycles in four
  task automatic run_traffic(input int cycles);
    repeat (cycles) begin
      drive_word(({$random(seed)} % 4) != 0);
      next_cycle();
    end
    ustrm_valid = 1'b0;
  endtask

  task automatic drain();
    while (sb_words.size() != 0) next_cycle();
    // Let credit returns settle
    repeat (6) next_cycle();
  endtask

  task automatic take_offline();
    ustrm_valid = 1'b0;
    tx_online   = 1'b0;
    rx_online   = 1'b0;
    repeat (3) next_cycle();
  endtask

  // Credit grant must follow tx_online by the transmit delay
  task automatic bring_online();
    int n;
    n = 0;
    tx_online = 1'b1;
    rx_online = 1'b1;
    while (!ustrm_credit_ok && n < 50) begin
      @(posedge clk_wr);
      n++;
      @(negedge clk_wr);
    end
    assert (n == DELAY_XZ + 1) else fail_value("ustrm_credit_ok rise cycle", n, DELAY_XZ + 1);
    next_cycle();
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    int drop_base;
    int accept_base;
    seed = 32'haaad_307f;
    cycle_cnt = 0;
    exp_drop = 0;
    delivered_cnt = 0;
    accept_cnt = 0;
    exhaust_accepts = 0;
    exhaust_phase = 1'b0;
    gen1_accept_q = 1'b0;
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    loop_en = 1'b1;
    m_gen2_mode = 1'b1;
    init_upstream_credit = INIT_CREDIT;
    delay_x_value = DELAY_X;
    delay_xz_value = DELAY_XZ;
    ustrm_state = '0;
    ustrm_protid = '0;
    ustrm_data = '0;
    ustrm_dvalid = 1'b0;
    ustrm_crc = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Quiet outputs while offline
    repeat (3) begin
      next_cycle();
      assert (tx_phy0 == '0) else fail_value("tx_phy0", tx_phy0, 0);
      assert (tx_phy1 == '0) else fail_value("tx_phy1", tx_phy1, 0);
      assert (!dstrm_valid) else fail_value("dstrm_valid", dstrm_valid, 0);
      assert (!ustrm_credit_ok) else fail_value("ustrm_credit_ok", ustrm_credit_ok, 0);
    end
    bring_online();

    // Gen2 then Gen1 loopback
    run_traffic(G2_CYCLES);
    drain();
    m_gen2_mode = 1'b0;
    run_traffic(G1_CYCLES);
    drain();
    m_gen2_mode = 1'b1;
    repeat (4) next_cycle();

    // Offers every cycle on a fresh grant with the link cut
    loop_en = 1'b0;
    take_offline();
    bring_online();
    drop_base = tx_upstream_debug_status;
    exhaust_phase = 1'b1;
    repeat (EXH_CYCLES) begin
      drive_word(1'b1);
      next_cycle();
    end
    ustrm_valid = 1'b0;
    exhaust_phase = 1'b0;
    assert (exhaust_accepts == INIT_CREDIT)
      else fail_value("accepted words", exhaust_accepts, INIT_CREDIT);
    assert (tx_upstream_debug_status - drop_base == EXH_CYCLES - INIT_CREDIT)
      else fail_value("tx_upstream_debug_status delta", tx_upstream_debug_status - drop_base,
                      EXH_CYCLES - INIT_CREDIT);

    // Credits come back over the restored loop
    loop_en = 1'b1;
    take_offline();
    bring_online();
    accept_base = accept_cnt;
    run_traffic(REC_CYCLES);
    drain();
    assert (accept_cnt - accept_base > INIT_CREDIT)
      else fail_text("No credits came back over the restored link");
    assert (rx_downstream_debug_status == delivered_cnt)
      else fail_value("rx_downstream_debug_status", rx_downstream_debug_status,
                      delivered_cnt);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
common/lpif_link_pkg.sv
auto_sync/lpif_auto_sync.sv
verilog/lpif_field_pack.sv
phy_concat/lpif_phy_concat.sv
verilog/lpif_credit_ctrl.sv
verilog/lpif_link_top.sv
tb/lpif_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the LPIF link testbench with Verilator.
# The exit status is the simulator's: nonzero on any failing check.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lpif_link_tb \
  -f build.f \
  -o lpif_link_sim

./obj_dir/lpif_link_sim
